/* design/rv_pkg.sv */
package rv_pkg;

  // datapath and register file sizes
  localparam int unsigned xlen       = 32;
  localparam int unsigned reg_count  = 32;
  localparam int unsigned reg_addr_w = 5;

  // major opcodes of the supported groups
  localparam logic [6:0] opc_op     = 7'b0110011;  // register-register alu
  localparam logic [6:0] opc_op_imm = 7'b0010011;  // register-immediate alu
  localparam logic [6:0] opc_system = 7'b1110011;  // ecall lives here

  // ecall looks at a7 and stops on the exit code
  localparam logic [reg_addr_w-1:0] halt_reg  = 5'd17;
  localparam logic [xlen-1:0]       halt_code = 32'd10;

  // accept to writeback, in cycles
  localparam int unsigned pipe_depth = 3;

  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9
  } alu_op_e;

  // one instruction word, two layouts
  // r_fmt carries funct7/rs2, i_fmt carries the 12-bit immediate in the same bits
  typedef union packed {
    struct packed {
      logic [6:0]            funct7;
      logic [reg_addr_w-1:0] rs2;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } r_fmt;
    struct packed {
      logic [11:0]           imm;
      logic [reg_addr_w-1:0] rs1;
      logic [2:0]            funct3;
      logic [reg_addr_w-1:0] rd;
      logic [6:0]            opcode;
    } i_fmt;
  } instr_u;

endpackage

/* design/pipe_if.sv */
`timescale 1ns/1ps

// decode to execute bundle, registered on the decode side
interface dec_ex_if;

  logic                          valid;
  logic [rv_pkg::xlen-1:0]       op_a;       // rs1 value read in decode
  logic [rv_pkg::xlen-1:0]       op_b;       // rs2 value read in decode
  logic [rv_pkg::xlen-1:0]       imm;
  logic                          use_imm;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic                          reg_write;  // low for rd == 0
  logic                          is_ecall;

  modport src (
    output valid, op_a, op_b, imm, use_imm, alu_op,
    output rs1, rs2, rd, reg_write, is_ecall
  );

  modport dst (
    input valid, op_a, op_b, imm, use_imm, alu_op,
    input rs1, rs2, rd, reg_write, is_ecall
  );

endinterface

// execute to result, combinational on the execute side
interface ex_res_if;

  logic                          valid;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       data;
  logic                          reg_write;
  logic                          halt;       // ecall saw the exit code

  modport src (
    output valid, rd, data, reg_write, halt
  );

  modport dst (
    input valid, rd, data, reg_write, halt
  );

endinterface

/* design/decode.sv */
`timescale 1ns/1ps

module decode (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          instr_valid,
  input  logic [rv_pkg::xlen-1:0]       instr,
  input  logic                          wb_valid,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  dec_ex_if.src                         dec_ex
);

  rv_pkg::instr_u instr_q;    // accepted instruction word
  logic           instr_v_q;

  logic [rv_pkg::xlen-1:0] regs [rv_pkg::reg_count];

  logic [6:0]                    opcode;
  logic [2:0]                    funct3;
  logic                          is_op;
  logic                          is_op_imm;
  logic                          is_ecall;
  logic                          is_shift_imm;
  logic [rv_pkg::reg_addr_w-1:0] rs1;
  logic [rv_pkg::reg_addr_w-1:0] rs2;
  logic [rv_pkg::reg_addr_w-1:0] rd;
  logic [rv_pkg::xlen-1:0]       imm;
  logic                          reg_write;
  rv_pkg::alu_op_e               alu_op;
  logic [rv_pkg::xlen-1:0]       rs1_val;
  logic [rv_pkg::xlen-1:0]       rs2_val;

  always_ff @(posedge clk) begin
    if (reset) begin
      instr_v_q <= 1'b0;
    end else begin
      instr_v_q <= instr_valid;
    end
  end

  always_ff @(posedge clk) begin
    instr_q <= instr;
  end

  assign opcode    = instr_q.r_fmt.opcode;
  assign funct3    = instr_q.r_fmt.funct3;
  assign is_op     = opcode == rv_pkg::opc_op;
  assign is_op_imm = opcode == rv_pkg::opc_op_imm;

  // ecall is the all-zero system encoding
  assign is_ecall = (opcode == rv_pkg::opc_system) && (funct3 == 3'b000) &&
                    (instr_q.i_fmt.imm == 12'h000);

  assign is_shift_imm = is_op_imm && (funct3 == 3'b001 || funct3 == 3'b101);

  assign rs1 = is_ecall ? rv_pkg::halt_reg : instr_q.r_fmt.rs1;  // ecall reads a7
  assign rs2 = instr_q.r_fmt.rs2;
  assign rd  = instr_q.r_fmt.rd;

  // shamt sits in the rs2 field, the rest sign extend imm[11]
  assign imm = is_shift_imm ?
               {{(rv_pkg::xlen - rv_pkg::reg_addr_w){1'b0}}, instr_q.r_fmt.rs2} :
               {{(rv_pkg::xlen - 12){instr_q.i_fmt.imm[11]}}, instr_q.i_fmt.imm};

  assign reg_write = (is_op || is_op_imm) && (rd != '0);

  // funct7[5] picks sub and sra, only register form has sub
  always_comb begin
    case (funct3)
      3'b000:  alu_op = (is_op && instr_q.r_fmt.funct7[5]) ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  alu_op = rv_pkg::alu_sll;
      3'b010:  alu_op = rv_pkg::alu_slt;
      3'b011:  alu_op = rv_pkg::alu_sltu;
      3'b100:  alu_op = rv_pkg::alu_xor;
      3'b101:  alu_op = instr_q.r_fmt.funct7[5] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  alu_op = rv_pkg::alu_or;
      default: alu_op = rv_pkg::alu_and;
    endcase
  end

  // register file, x0 is never written
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < rv_pkg::reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // same-cycle write shows through on read
  assign rs1_val = (wb_valid && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_val = (wb_valid && wb_rd == rs2) ? wb_data : regs[rs2];

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_ex.valid <= 1'b0;
    end else begin
      dec_ex.valid <= instr_v_q;
    end
  end

  // execute stage input register
  always_ff @(posedge clk) begin
    dec_ex.op_a      <= rs1_val;
    dec_ex.op_b      <= rs2_val;
    dec_ex.imm       <= imm;
    dec_ex.use_imm   <= is_op_imm;
    dec_ex.alu_op    <= alu_op;
    dec_ex.rs1       <= rs1;
    dec_ex.rs2       <= rs2;
    dec_ex.rd        <= rd;
    dec_ex.reg_write <= reg_write;
    dec_ex.is_ecall  <= is_ecall;
  end

endmodule

/* design/execute.sv */
`timescale 1ns/1ps

module execute (
  dec_ex_if.dst                         dec_ex,
  input  logic                          wb_valid,
  input  logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input  logic [rv_pkg::xlen-1:0]       wb_data,
  ex_res_if.src                         ex_res
);

  logic [rv_pkg::xlen-1:0] src_a;
  logic [rv_pkg::xlen-1:0] src_b;
  logic [rv_pkg::xlen-1:0] alu_b;
  logic [rv_pkg::xlen-1:0] alu_y;
  logic [4:0]              shamt;
  logic                    lt_signed;
  logic                    lt_unsigned;

  // forward from the instruction one ahead, now in writeback
  // farther producers were already picked up by the register file read
  // wb_valid only comes with a nonzero rd, so x0 is never overridden
  assign src_a = (wb_valid && wb_rd == dec_ex.rs1) ? wb_data : dec_ex.op_a;
  assign src_b = (wb_valid && wb_rd == dec_ex.rs2) ? wb_data : dec_ex.op_b;

  assign alu_b = dec_ex.use_imm ? dec_ex.imm : src_b;

  assign shamt = alu_b[4:0];  // low five bits only

  assign lt_signed   = $signed(src_a) < $signed(alu_b);
  assign lt_unsigned = src_a < alu_b;

  always_comb begin
    case (dec_ex.alu_op)
      rv_pkg::alu_add: begin
        alu_y = src_a + alu_b;
      end
      rv_pkg::alu_sub: begin
        alu_y = src_a - alu_b;  // wraps on underflow
      end
      rv_pkg::alu_and: begin
        alu_y = src_a & alu_b;
      end
      rv_pkg::alu_or: begin
        alu_y = src_a | alu_b;
      end
      rv_pkg::alu_xor: begin
        alu_y = src_a ^ alu_b;
      end
      rv_pkg::alu_sll: begin
        alu_y = src_a << shamt;
      end
      rv_pkg::alu_srl: begin
        alu_y = src_a >> shamt;
      end
      rv_pkg::alu_sra: begin
        alu_y = $unsigned($signed(src_a) >>> shamt);  // keeps the sign bit
      end
      rv_pkg::alu_slt: begin
        alu_y = {{(rv_pkg::xlen - 1){1'b0}}, lt_signed};
      end
      default: begin
        alu_y = {{(rv_pkg::xlen - 1){1'b0}}, lt_unsigned};  // sltu
      end
    endcase
  end

  assign ex_res.valid     = dec_ex.valid;
  assign ex_res.rd        = dec_ex.rd;
  assign ex_res.data      = alu_y;
  assign ex_res.reg_write = dec_ex.reg_write;

  // halt check sees the forwarded a7
  assign ex_res.halt = dec_ex.valid && dec_ex.is_ecall && (src_a == rv_pkg::halt_code);

endmodule

/* design/result.sv */
`timescale 1ns/1ps

module result (
  input  logic                          clk,
  input  logic                          reset,
  ex_res_if.dst                         ex_res,
  output logic                          wb_valid,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          is_halted
);

  // control bits of the result stage
  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid  <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      // nothing behind the ecall gets written
      wb_valid <= ex_res.valid && ex_res.reg_write && !is_halted;
      if (ex_res.valid && ex_res.halt) begin
        is_halted <= 1'b1;  // sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    wb_rd   <= ex_res.rd;
    wb_data <= ex_res.data;
  end

endmodule

/* design/rv_core.sv */
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          instr_valid,
  input  logic [rv_pkg::xlen-1:0]       instr,
  output logic                          wb_valid,
  output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  output logic [rv_pkg::xlen-1:0]       wb_data,
  output logic                          is_halted
);

  dec_ex_if dec_ex ();
  ex_res_if ex_res ();

  // writeback ports fan out to the register file and the forwarding mux
  decode u_decode (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .dec_ex      (dec_ex.src)
  );

  execute u_execute (
    .dec_ex   (dec_ex.dst),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data),
    .ex_res   (ex_res.src)
  );

  result u_result (
    .clk       (clk),
    .reset     (reset),
    .ex_res    (ex_res.dst),
    .wb_valid  (wb_valid),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .is_halted (is_halted)
  );

endmodule

/* dv/rv_core_checker.sv */
`timescale 1ns/1ps

module rv_core_checker (
  input logic                          clk,
  input logic                          reset,
  input logic                          wb_valid,
  input logic [rv_pkg::reg_addr_w-1:0] wb_rd,
  input logic                          is_halted
);

  logic assert_failed = 1'b0;  // read by the testbench

  // nothing retires once the core has halted
  no_wb_after_halt: assert property (@(posedge clk) disable iff (reset)
    is_halted |=> !wb_valid)
    else begin
      assert_failed = 1'b1;
      $error("writeback seen after the core halted");
    end

  wb_rd_nonzero: assert property (@(posedge clk) disable iff (reset)
    wb_valid |-> (wb_rd != '0))
    else begin
      assert_failed = 1'b1;
      $error("writeback to x0");
    end

  // sticky halt
  halt_held: assert property (@(posedge clk)
    (is_halted && !reset) |=> is_halted)
    else begin
      assert_failed = 1'b1;
      $error("is_halted dropped without reset");
    end

  reset_state: assert property (@(posedge clk)
    reset |=> (!wb_valid && !is_halted))
    else begin
      assert_failed = 1'b1;
      $error("wb_valid or is_halted high after reset");
    end

endmodule

bind rv_core rv_core_checker u_checker (
  .clk       (clk),
  .reset     (reset),
  .wb_valid  (wb_valid),
  .wb_rd     (wb_rd),
  .is_halted (is_halted)
);

/* dv/tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  typedef struct packed {
    logic [31:0] word;
    int          gap;   // bubbles ahead of the row, negative means random
    logic        wb;
    logic [4:0]  rd;
    logic [31:0] data;
  } row_t;

  typedef struct packed {
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_exp_t;

  logic        clk;
  logic        reset;
  logic        instr_valid;
  logic [31:0] instr;
  logic        wb_valid;
  logic [4:0]  wb_rd;
  logic [31:0] wb_data;
  logic        is_halted;

  row_t        rows[$];
  wb_exp_t     pending[$];     // in retirement order
  int unsigned cycle_count = 0;
  int unsigned cycle_limit = 0;

  rv_core u_dut (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .wb_valid    (wb_valid),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .is_halted   (is_halted)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic logic [31:0] r_type(input int funct7, input int rs2, input int rs1,
                                         input int funct3, input int rd);
    return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], rv_pkg::opc_op};
  endfunction

  function automatic logic [31:0] i_type(input int imm, input int rs1, input int funct3,
                                         input int rd);
    return {imm[11:0], rs1[4:0], funct3[2:0], rd[4:0], rv_pkg::opc_op_imm};
  endfunction

  task automatic end_with_failure();
    $display("tests failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s got %h expected %h", $time, what, got, exp);
      end_with_failure();
    end
  endtask

  task automatic add_row(input logic [31:0] word, input int gap, input logic wb, input int rd,
                         input logic [31:0] data);
    row_t r;
    r.word = word;
    r.gap  = gap;
    r.wb   = wb;
    r.rd   = rd[4:0];
    r.data = data;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // immediate group, x1 = -5 and x2 = 100
    add_row(i_type(-5, 0, 0, 1), -1, 1'b1, 1, 32'hffff_fffb);
    add_row(i_type(100, 0, 0, 2), -1, 1'b1, 2, 32'd100);
    add_row(i_type(1, 1, 2, 3), -1, 1'b1, 3, 32'd1);             // slti, signed
    add_row(i_type(1, 1, 3, 4), -1, 1'b1, 4, 32'd0);             // sltiu, unsigned
    add_row(i_type(4, 2, 1, 5), -1, 1'b1, 5, 32'h0000_0640);     // slli
    add_row(i_type(4, 1, 5, 6), -1, 1'b1, 6, 32'h0fff_ffff);     // srli
    add_row(i_type('h401, 1, 5, 7), -1, 1'b1, 7, 32'hffff_fffd); // srai
    add_row(i_type(-1, 2, 4, 8), -1, 1'b1, 8, 32'hffff_ff9b);    // xori
    add_row(i_type('h0f, 2, 6, 9), -1, 1'b1, 9, 32'h0000_006f);  // ori
    add_row(i_type('hf0, 1, 7, 10), -1, 1'b1, 10, 32'h0000_00f0); // andi
    // register group on x11 = 7, x12 = 9
    add_row(i_type(7, 0, 0, 11), -1, 1'b1, 11, 32'd7);
    add_row(i_type(9, 0, 0, 12), -1, 1'b1, 12, 32'd9);
    add_row(r_type(0, 12, 11, 0, 13), -1, 1'b1, 13, 32'd16);
    add_row(r_type('h20, 12, 11, 0, 14), -1, 1'b1, 14, 32'hffff_fffe);  // sub wraps
    add_row(r_type(0, 2, 1, 7, 15), -1, 1'b1, 15, 32'h0000_0060);
    add_row(r_type(0, 12, 11, 6, 16), -1, 1'b1, 16, 32'h0000_000f);
    add_row(r_type(0, 12, 11, 4, 18), -1, 1'b1, 18, 32'h0000_000e);
    add_row(r_type(0, 12, 11, 1, 19), -1, 1'b1, 19, 32'h0000_0e00);
    add_row(r_type(0, 11, 1, 5, 20), -1, 1'b1, 20, 32'h01ff_ffff);
    add_row(r_type('h20, 11, 1, 5, 21), -1, 1'b1, 21, 32'hffff_ffff);   // sra of -5
    add_row(r_type(0, 2, 1, 2, 22), -1, 1'b1, 22, 32'd1);
    add_row(r_type(0, 2, 1, 3, 23), -1, 1'b1, 23, 32'd0);
    // dependent chain spaced out
    add_row(i_type(3, 0, 0, 24), -1, 1'b1, 24, 32'd3);
    add_row(i_type(5, 24, 0, 25), 3, 1'b1, 25, 32'd8);
    add_row(r_type(0, 24, 25, 0, 26), 3, 1'b1, 26, 32'd11);
    add_row(r_type('h20, 24, 26, 0, 27), 3, 1'b1, 27, 32'd8);
    add_row(i_type(2, 27, 0, 28), 3, 1'b1, 28, 32'd10);
    add_row(i_type(1, 28, 1, 29), 3, 1'b1, 29, 32'd20);
    // same chain back to back on registers holding stale values
    add_row(i_type(3, 0, 0, 5), -1, 1'b1, 5, 32'd3);
    add_row(i_type(5, 5, 0, 6), 0, 1'b1, 6, 32'd8);              // distance one
    add_row(r_type(0, 5, 6, 0, 7), 0, 1'b1, 7, 32'd11);
    add_row(r_type('h20, 5, 7, 0, 8), 0, 1'b1, 8, 32'd8);        // x5 at distance three
    add_row(i_type(2, 8, 0, 9), 1, 1'b1, 9, 32'd10);             // distance two
    add_row(i_type(1, 9, 1, 10), 2, 1'b1, 10, 32'd20);           // distance three
    // youngest producer has to win
    add_row(i_type(1, 0, 0, 30), -1, 1'b1, 30, 32'd1);
    add_row(i_type(1, 30, 0, 30), 0, 1'b1, 30, 32'd2);
    add_row(i_type(1, 30, 0, 30), 0, 1'b1, 30, 32'd3);
    // x0 and a dropped opcode
    add_row(i_type('h55, 0, 0, 31), -1, 1'b1, 31, 32'h0000_0055);
    add_row(i_type(5, 0, 0, 0), 0, 1'b0, 0, 32'd0);
    add_row(r_type(0, 0, 0, 0, 31), 0, 1'b1, 31, 32'd0);
    add_row(32'h0001_2083, -1, 1'b0, 0, 32'd0);                  // lw x1, 0(x2)
    add_row(i_type(0, 1, 0, 3), 0, 1'b1, 3, 32'hffff_fffb);
    // ecall, first with a7 = 9 then with a7 = 10
    add_row(i_type(9, 0, 0, 17), -1, 1'b1, 17, 32'd9);
    add_row(32'h0000_0073, -1, 1'b0, 0, 32'd0);
    add_row(i_type(1, 11, 0, 11), -1, 1'b1, 11, 32'd8);
    add_row(i_type(10, 0, 0, 17), -1, 1'b1, 17, 32'd10);
    add_row(32'h0000_0073, 0, 1'b0, 0, 32'd0);
    add_row(i_type(1, 0, 0, 12), 0, 1'b0, 0, 32'd0);             // behind the halt
    add_row(r_type(0, 12, 11, 0, 13), -1, 1'b0, 0, 32'd0);
    add_row(i_type(3, 0, 0, 17), -1, 1'b0, 0, 32'd0);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      end_with_failure();
    end
  end

  // outputs are settled at the falling edge
  always @(negedge clk) begin
    wb_exp_t exp_wb;
    if (u_dut.u_checker.assert_failed) begin
      $display("an assertion in the bound checker fired");
      end_with_failure();
    end
    if (reset === 1'b0 && wb_valid === 1'b1) begin
      compare("writeback with nothing pending", {31'b0, pending.size() == 0}, 32'd0);
      compare("is_halted during writeback", {31'b0, is_halted}, 32'd0);
      exp_wb = pending.pop_front();
      compare("wb_rd", {27'b0, wb_rd}, {27'b0, exp_wb.rd});
      compare("wb_data", wb_data, exp_wb.data);
    end
  end

  initial begin
    int unsigned bubbles;
    reset       = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    void'($urandom(50880));
    build_table();
    cycle_limit = 2 * rows.size() + rv_pkg::pipe_depth + 20;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[i]) begin
      if (rows[i].gap < 0) begin
        bubbles = $urandom % 2;
      end else begin
        bubbles = rows[i].gap;
      end
      repeat (bubbles) begin
        instr_valid <= 1'b0;
        @(posedge clk);
      end
      instr_valid <= 1'b1;
      instr       <= rows[i].word;
      if (rows[i].wb) begin
        pending.push_back({rows[i].rd, rows[i].data});
      end
      @(posedge clk);
    end
    instr_valid <= 1'b0;
    while (pending.size() != 0) begin
      @(posedge clk);
    end
    repeat (rv_pkg::pipe_depth + 1) @(posedge clk);  // catch stray writebacks
    @(negedge clk);
    compare("is_halted at end of run", {31'b0, is_halted}, 32'd1);
    if (u_dut.u_checker.assert_failed) begin
      $display("an assertion in the bound checker fired");
      end_with_failure();
    end else begin
      $display("all tests passed");
      $finish;
    end
  end

endmodule

/* build.f */
design/rv_pkg.sv
design/pipe_if.sv
design/decode.sv
design/execute.sv
design/result.sv
design/rv_core.sv
dv/rv_core_checker.sv
dv/tb_rv_core.sv

/* Makefile */
SIM := obj_dir/Vtb_rv_core

.PHONY: all run clean

all: $(SIM)

$(SIM): build.f $(wildcard design/*.sv dv/*.sv)
	verilator --binary --timing --assert -j 0 -f build.f --top-module tb_rv_core -Mdir obj_dir

# the run fails unless the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir
